/* files.f */
+incdir+common
common/scan_pkg.sv
design/stream_tracker.sv
regex_engine/keyword_dfa.sv
regex_engine/rule_matcher.sv
design/scan_top.sv
sim/scan_checker.sv
sim/scan_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the keyword scanner testbench with Verilator
# The exit status is 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module scan_tb -o scan_sim \
  && ./obj_dir/scan_sim +verilator+error+limit+100 2>&1 | tee sim.log

grep -qF '*** TEST PASSED ***' sim.log \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }

/* sim/scan_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_config.svh"

module scan_tb
  import scan_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_RANDOM  = 40;
  // Directed packets plus random ones
  localparam int NUM_PACKETS = 12 + NUM_RANDOM;
  // Upper bound per packet, framing and a config write included
  localparam int PKT_CYCLES  = 60;
  localparam int TIMEOUT_NS  = NUM_PACKETS * PKT_CYCLES * 2 * CLK_PERIOD;

  logic         clk;
  logic         rst_n;
  logic         sop;
  logic         eop;
  stream_id_t   stream_id;
  char_t        char_in;
  logic         char_vld;
  logic         cfg_we;
  stream_id_t   cfg_stream;
  rule_mask_t   cfg_mask;
  match_count_t count_0;
  match_count_t count_1;
  logic         fired_0;
  logic         fired_1;

  // Reference model, prefix lengths saved per rule and stream
  string        keywords [2];
  int           model_prefix [2][`SCAN_NUM_STREAMS] = '{default: 0};
  rule_mask_t   model_mask [`SCAN_NUM_STREAMS] = '{default: '0};
  match_count_t exp_count [2] = '{default: '0};
  logic         exp_fired [2] = '{default: 1'b0};

  int    errors = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  string test_name = "reset";

  scan_top i_scan_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // Inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  // Prefix length after one character, keyword length on a full match
  function automatic int next_prefix(input string kw, input int len, input char_t c);
    if (c == kw[len])
      return (len == kw.len() - 1) ? kw.len() : len + 1;
    else if (c == kw[0])
      return 1;
    return 0;
  endfunction

  task automatic write_mask(input int sid, input rule_mask_t mask);
    cfg_we     = 1'b1;
    cfg_stream = stream_id_t'(sid);
    cfg_mask   = mask;
    next_cycle();
    cfg_we          = 1'b0;
    model_mask[sid] = mask;
  endtask

  task automatic check_outputs();
    match_count_t act_count [2];
    logic         act_fired [2];
    act_count = '{count_0, count_1};
    act_fired = '{fired_0, fired_1};
    for (int r = 0; r < 2; r++)
    begin
      assert (act_count[r] === exp_count[r])
      else
      begin
        $display("FAIL %0d ns: %s count_%0d expected %0d, actual %0d",
                 $time, test_name, r, exp_count[r], act_count[r]);
        errors++;
      end
      assert (act_fired[r] === exp_fired[r])
      else
      begin
        $display("FAIL %0d ns: %s fired_%0d expected %0b, actual %0b",
                 $time, test_name, r, exp_fired[r], act_fired[r]);
        errors++;
      end
    end
  endtask

  // One framed packet, model updated alongside, checked 3 cycles after eop
  task automatic send_packet(input int sid, input string payload);
    int   prefix [2];
    logic hit [2];
    int   step;
    for (int r = 0; r < 2; r++)
    begin
      prefix[r] = model_prefix[r][sid];
      hit[r]    = 1'b0;
    end
    sop       = 1'b1;
    stream_id = stream_id_t'(sid);
    next_cycle();
    sop = 1'b0;
    repeat (4) next_cycle();
    for (int i = 0; i < payload.len(); i++)
    begin
      char_in  = payload[i];
      char_vld = 1'b1;
      for (int r = 0; r < 2; r++)
      begin
        step      = next_prefix(keywords[r], prefix[r], payload[i]);
        hit[r]    = hit[r] || (step == keywords[r].len());
        prefix[r] = (step == keywords[r].len()) ? 0 : step;
      end
      next_cycle();
    end
    char_vld = 1'b0;
    repeat (5) next_cycle();
    eop = 1'b1;
    next_cycle();
    eop = 1'b0;
    // Disabled rule drops its flag and keeps the old saved prefix
    for (int r = 0; r < 2; r++)
    begin
      exp_fired[r] = model_mask[sid][r] && hit[r];
      if (model_mask[sid][r])
      begin
        exp_count[r]         = exp_count[r] + match_count_t'(hit[r]);
        model_prefix[r][sid] = prefix[r];
      end
    end
    repeat (3) next_cycle();
    check_outputs();
  endtask

  task automatic report_test(input int errs_before);
    if (errors == errs_before)
    begin
      tests_passed++;
      $display("Test %s: ok", test_name);
    end
    else
    begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", test_name, errors - errs_before);
    end
  endtask

  initial
  begin
    int    errs_before;
    int    sid;
    int    pick;
    int    checker_fails;
    string payload;
    string filler;
    // Lowercase letters found in neither keyword
    filler      = "bdfhijlmnopqrsuvwxyz";
    keywords[0] = "GET";
    keywords[1] = "attack";
    void'($urandom(32'hfbe606c9));
    rst_n      = 1'b0;
    sop        = 1'b0;
    eop        = 1'b0;
    stream_id  = '0;
    char_in    = '0;
    char_vld   = 1'b0;
    cfg_we     = 1'b0;
    cfg_stream = '0;
    cfg_mask   = '0;
    repeat (8) next_cycle();
    rst_n = 1'b1;
    repeat (2) next_cycle();

    errs_before = errors;
    check_outputs();
    report_test(errs_before);

    // Single count per packet, even with two hits
    test_name   = "get_count";
    errs_before = errors;
    write_mask(1, 2'b11);
    send_packet(1, "xyGETzz");
    send_packet(1, "GETzzGET");
    report_test(errs_before);

    // Split keyword joins only within one stream
    test_name   = "carry";
    errs_before = errors;
    write_mask(2, 2'b11);
    write_mask(3, 2'b11);
    write_mask(4, 2'b11);
    send_packet(2, "zzatt");
    send_packet(2, "ackzz");
    send_packet(3, "zzatt");
    send_packet(4, "ackzz");
    report_test(errs_before);

    // Unseen stream starts at 0 while the DFA still holds another prefix
    test_name   = "new_stream";
    errs_before = errors;
    write_mask(12, 2'b11);
    write_mask(13, 2'b11);
    send_packet(12, "zzattGE");
    send_packet(13, "Tack");
    report_test(errs_before);

    // Rule 1 off for stream 8, then back on with its last enabled prefix
    test_name   = "disable";
    errs_before = errors;
    write_mask(8, 2'b01);
    send_packet(8, "zattack");
    write_mask(8, 2'b11);
    send_packet(8, "xat");
    write_mask(8, 2'b01);
    send_packet(8, "tzz");
    write_mask(8, 2'b11);
    send_packet(8, "tack");
    report_test(errs_before);

    test_name   = "random";
    errs_before = errors;
    for (int p = 0; p < NUM_RANDOM; p++)
    begin
      sid = $urandom_range(0, 15);
      if ($urandom_range(0, 3) == 0)
        write_mask(sid, rule_mask_t'($urandom_range(0, 3)));
      payload = "";
      repeat ($urandom_range(1, 4))
      begin
        pick = $urandom_range(0, 5);
        case (pick)
          0: payload = {payload, keywords[0]};
          1: payload = {payload, keywords[1].substr(0, $urandom_range(0, 5))};
          2: payload = {payload, keywords[1].substr($urandom_range(0, 5), 5)};
          default:
          begin
            pick    = $urandom_range(0, filler.len() - 1);
            payload = {payload, filler.substr(pick, pick)};
          end
        endcase
      end
      send_packet(sid, payload);
    end
    report_test(errs_before);

    checker_fails = i_scan_top.i_scan_checker.fail_count;
    $display("Tests passed: %0d, tests failed: %0d, assertion failures: %0d",
             tests_passed, tests_failed, checker_fails);
    if (tests_failed == 0 && checker_fails == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/scan_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module scan_checker
  import scan_pkg::*;
(
  input logic         clk,
  input logic         rst_n,
  input logic         load_state,
  input logic         eop,
  input match_count_t count_0,
  input match_count_t count_1,
  input logic         fired_0,
  input logic         fired_1
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Sticky flags clear as soon as a new packet is loaded
  fired_low: assert property (@(posedge clk) disable iff (!rst_n)
    load_state |=> !fired_0 && !fired_1)
  else
  begin
    $error("fired still high one cycle after load_state");
    fail_count++;
  end

  // Count 0 moves only 2 cycles after eop, and by one
  count_0_step: assert property (@(posedge clk) disable iff (!rst_n)
    count_0 != $past(count_0) |->
      $past(eop, 2) && count_0 == match_count_t'($past(count_0) + 1))
  else
  begin
    $error("count_0 changed outside an eop or by more than one");
    fail_count++;
  end

  // Same rule for count 1
  count_1_step: assert property (@(posedge clk) disable iff (!rst_n)
    count_1 != $past(count_1) |->
      $past(eop, 2) && count_1 == match_count_t'($past(count_1) + 1))
  else
  begin
    $error("count_1 changed outside an eop or by more than one");
    fail_count++;
  end

  // Synchronous reset clears both rule outputs
  reset_clear: assert property (@(posedge clk)
    !rst_n |=> count_0 == 0 && count_1 == 0 && !fired_0 && !fired_1)
  else
  begin
    $error("outputs not cleared by reset");
    fail_count++;
  end

endmodule

bind scan_top scan_checker i_scan_checker (
  .clk        (clk),
  .rst_n      (rst_n),
  .load_state (load_state),
  .eop        (eop),
  .count_0    (count_0),
  .count_1    (count_1),
  .fired_0    (fired_0),
  .fired_1    (fired_1)
);

`default_nettype wire

/* design/scan_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_config.svh"

module scan_top
  import scan_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         sop,
  input  logic         eop,
  input  stream_id_t   stream_id,
  input  char_t        char_in,
  input  logic         char_vld,
  input  logic         cfg_we,
  input  stream_id_t   cfg_stream,
  input  rule_mask_t   cfg_mask,
  output match_count_t count_0,
  output match_count_t count_1,
  output logic         fired_0,
  output logic         fired_1
);

  // Aligned framing from the tracker
  logic       load_state;
  logic       new_stream;
  logic       eop_d;
  logic       char_vld_d;
  stream_id_t stream_id_d;
  char_t      char_d;
  rule_mask_t enable;

  stream_tracker i_stream_tracker (
    .clk         (clk),
    .rst_n       (rst_n),
    .sop         (sop),
    .eop         (eop),
    .char_vld    (char_vld),
    .cfg_we      (cfg_we),
    .stream_id   (stream_id),
    .cfg_stream  (cfg_stream),
    .char_in     (char_in),
    .cfg_mask    (cfg_mask),
    .load_state  (load_state),
    .new_stream  (new_stream),
    .eop_d       (eop_d),
    .char_vld_d  (char_vld_d),
    .stream_id_d (stream_id_d),
    .char_d      (char_d),
    .enable      (enable)
  );

  // Rule 0 looks for GET
  rule_matcher #(
    .KEYWORD_LEN (3),
    .KEYWORD     ("GET")
  ) i_rule_0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .eop        (eop_d),
    .load_state (load_state),
    .new_stream (new_stream),
    .enable     (enable[0]),
    .char_vld   (char_vld_d),
    .char_in    (char_d),
    .stream_id  (stream_id_d),
    .count      (count_0),
    .fired      (fired_0)
  );

  // Rule 1 looks for attack
  rule_matcher #(
    .KEYWORD_LEN (6),
    .KEYWORD     ("attack")
  ) i_rule_1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .eop        (eop_d),
    .load_state (load_state),
    .new_stream (new_stream),
    .enable     (enable[1]),
    .char_vld   (char_vld_d),
    .char_in    (char_d),
    .stream_id  (stream_id_d),
    .count      (count_1),
    .fired      (fired_1)
  );

endmodule

`default_nettype wire

/* regex_engine/rule_matcher.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_config.svh"

module rule_matcher
  import scan_pkg::*;
#(
  parameter int                         KEYWORD_LEN = 3,
  parameter logic [8*KEYWORD_LEN-1:0]   KEYWORD     = "GET"
)
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         eop,
  input  logic         load_state,
  input  logic         new_stream,
  input  logic         enable,
  input  logic         char_vld,
  input  char_t        char_in,
  input  stream_id_t   stream_id,
  output match_count_t count,
  output logic         fired
);

  // Saved DFA state per stream
  dfa_state_t state_mem [`SCAN_NUM_STREAMS];

  // Slot holds a state saved at an enabled eop
  logic [`SCAN_NUM_STREAMS-1:0] saved;

  // Restore stage
  logic       state_in_vld;
  dfa_state_t state_in;

  // Registers in front of the DFA
  logic       state_in_vld_r;
  dfa_state_t state_in_r;
  logic       char_vld_r;
  char_t      char_r;

  // DFA outputs and their registered copies
  dfa_state_t state_out;
  dfa_state_t state_out_r;
  logic       accept;
  logic       accept_r;

  // Sticky per-packet match
  logic       match_flag;

  assign fired = match_flag;

  // Restore strobe, one cycle after load_state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_in_vld <= 1'b0;
    else
      state_in_vld <= load_state;
  end

  // Fresh or never saved streams start from 0
  always_ff @(posedge clk)
  begin
    if (load_state)
      state_in <= (new_stream || !saved[stream_id]) ? '0 : state_mem[stream_id];
  end

  // State save at an enabled eop
  always_ff @(posedge clk)
  begin
    if (eop && enable)
      state_mem[stream_id] <= state_out_r;
  end

  // Pipeline control around the DFA
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld_r <= 1'b0;
      char_vld_r     <= 1'b0;
      accept_r       <= 1'b0;
    end
    else
    begin
      state_in_vld_r <= state_in_vld;
      char_vld_r     <= char_vld;
      accept_r       <= accept;
    end
  end

  // Pipeline payload
  always_ff @(posedge clk)
  begin
    state_in_r  <= state_in;
    char_r      <= char_in;
    state_out_r <= state_out;
  end

  // Match flag, packet count and saved bits
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count      <= '0;
      match_flag <= 1'b0;
      saved      <= '0;
    end
    else
    begin
      // New packet starts unmatched
      if (load_state)
        match_flag <= 1'b0;
      if (accept_r)
        match_flag <= 1'b1;
      if (eop)
      begin
        if (enable)
        begin
          // At most one count per packet
          count            <= count + match_count_t'(match_flag);
          saved[stream_id] <= 1'b1;
        end
        else
          match_flag <= 1'b0;
      end
    end
  end

  keyword_dfa #(
    .KEYWORD_LEN (KEYWORD_LEN),
    .KEYWORD     (KEYWORD)
  ) i_keyword_dfa (
    .clk          (clk),
    .rst_n        (rst_n),
    .char_vld     (char_vld_r),
    .state_in_vld (state_in_vld_r),
    .char_in      (char_r),
    .state_in     (state_in_r),
    .state_out    (state_out),
    .accept       (accept)
  );

endmodule

`default_nettype wire

/* regex_engine/keyword_dfa.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_config.svh"

module keyword_dfa
  import scan_pkg::*;
#(
  parameter int                         KEYWORD_LEN = 3,
  parameter logic [8*KEYWORD_LEN-1:0]   KEYWORD     = "GET"
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       char_vld,
  input  logic       state_in_vld,
  input  char_t      char_in,
  input  dfa_state_t state_in,
  output dfa_state_t state_out,
  output logic       accept
);

  // Last prefix length before a full match
  localparam dfa_state_t LAST = dfa_state_t'(KEYWORD_LEN - 1);

  // First keyword byte sits in the top byte of the string literal
  localparam char_t FIRST_CHAR = KEYWORD[8*KEYWORD_LEN-1 -: 8];

  char_t expect_char;

  // Byte the keyword needs at the current prefix length
  assign expect_char = KEYWORD[8*(KEYWORD_LEN - 1 - int'(state_out)) +: 8];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out <= '0;
      accept    <= 1'b0;
    end
    else
    begin
      accept <= 1'b0;
      // Restored state wins over a character
      if (state_in_vld)
        state_out <= state_in;
      else if (char_vld)
      begin
        if (char_in == expect_char)
        begin
          if (state_out == LAST)
          begin
            // Full keyword seen, start over
            state_out <= '0;
            accept    <= 1'b1;
          end
          else
            state_out <= state_out + 1'b1;
        end
        // Mismatch may still start a new keyword
        else if (char_in == FIRST_CHAR)
          state_out <= dfa_state_t'(1);
        else
          state_out <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/stream_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scan_config.svh"

module stream_tracker
  import scan_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sop,
  input  logic       eop,
  input  logic       char_vld,
  input  logic       cfg_we,
  input  stream_id_t stream_id,
  input  stream_id_t cfg_stream,
  input  char_t      char_in,
  input  rule_mask_t cfg_mask,
  output logic       load_state,
  output logic       new_stream,
  output logic       eop_d,
  output logic       char_vld_d,
  output stream_id_t stream_id_d,
  output char_t      char_d,
  output rule_mask_t enable
);

  // One bit per stream, set once a packet of that stream has started
  logic [`SCAN_NUM_STREAMS-1:0] seen;

  // Rule enables per stream, written by software
  rule_mask_t enable_tab [`SCAN_NUM_STREAMS];

  // Framing strobes and per-packet decisions
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen       <= '0;
      load_state <= 1'b0;
      new_stream <= 1'b0;
      eop_d      <= 1'b0;
      char_vld_d <= 1'b0;
      enable     <= '0;
      for (int i = 0; i < `SCAN_NUM_STREAMS; i++)
      begin
        enable_tab[i] <= '0;
      end
    end
    else
    begin
      // Strobes delayed so they line up with load_state
      load_state <= sop;
      eop_d      <= eop;
      char_vld_d <= char_vld;

      // At sop decide fresh stream and latch its enables
      if (sop)
      begin
        new_stream        <= !seen[stream_id];
        seen[stream_id]   <= 1'b1;
        enable            <= enable_tab[stream_id];
      end

      // Config write lands in one cycle
      if (cfg_we)
      begin
        enable_tab[cfg_stream] <= cfg_mask;
      end
    end
  end

  // Payload stage
  always_ff @(posedge clk)
  begin
    stream_id_d <= stream_id;
    char_d      <= char_in;
  end

endmodule

`default_nettype wire

/* common/scan_pkg.sv */
`default_nettype none

`include "scan_config.svh"

package scan_pkg;

  // Stream tag carried with every packet
  typedef logic [`SCAN_STREAM_W-1:0] stream_id_t;

  // Matched prefix length of one keyword DFA
  typedef logic [`SCAN_STATE_W-1:0] dfa_state_t;

  // Count of packets that held at least one match
  typedef logic [`SCAN_COUNT_W-1:0] match_count_t;

  // One input byte
  typedef logic [7:0] char_t;

  // Per-stream enable, bit n for rule n
  typedef logic [`SCAN_NUM_RULES-1:0] rule_mask_t;

endpackage

`default_nettype wire

/* common/scan_config.svh */
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

// Number of interleaved packet streams
`define SCAN_NUM_STREAMS 64

// Stream tag width, log2 of the stream count
`define SCAN_STREAM_W 6

// DFA state is the matched prefix length
`define SCAN_STATE_W 11

// Global matching packet counters
`define SCAN_COUNT_W 16

// Keyword rules in the scanner, one enable bit each
`define SCAN_NUM_RULES 2

`endif
